//--- hdl/aer_settings.svh
`ifndef AER_SETTINGS_SVH
`define AER_SETTINGS_SVH

// Pixels per row/column of the sensor array
`define AER_ARRAY_PIXELS 4

// Pixels per side of one level-0 group
`define AER_GROUP_SIZE 2

// Groups per side and in total
`define AER_GROUPS_PER_SIDE 2
`define AER_NUM_GROUPS 4

// Event polarities per pixel, bit 0 is ON and bit 1 is OFF
`define AER_POLARITY 2

// Global coordinate width and local address width inside a group
`define AER_ADDR_W 2
`define AER_LVL_ADD 1

`endif

//--- hdl/aer_pkg.sv
`default_nettype none

`include "aer_settings.svh"

package aer_pkg;

    // One bit per event polarity
    typedef logic [`AER_POLARITY-1:0] polarity_t;

    // Global x or y coordinate of a pixel
    typedef logic [`AER_ADDR_W-1:0] addr_t;

    // Group number in row-major order
    typedef logic [1:0] group_idx_t;

    // Root arbiter states
    typedef enum logic [0:0] {
        ROOT_IDLE,
        ROOT_SERVE
    } root_state_t;

endpackage

`default_nettype wire

//--- hdl/pixel_event_latch.sv
`default_nettype none

`include "aer_settings.svh"

module pixel_event_latch (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire aer_pkg::polarity_t [`AER_ARRAY_PIXELS-1:0][`AER_ARRAY_PIXELS-1:0] event_i,
    input  wire logic [`AER_ARRAY_PIXELS-1:0][`AER_ARRAY_PIXELS-1:0] ack_i,
    output aer_pkg::polarity_t [`AER_ARRAY_PIXELS-1:0][`AER_ARRAY_PIXELS-1:0] pend_o
);

    aer_pkg::polarity_t [`AER_ARRAY_PIXELS-1:0][`AER_ARRAY_PIXELS-1:0] pend_q;

    // The acknowledge clears the held bits first so that a strobe in the
    // same cycle survives and is read out later
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pend_q <= '0;
        end else begin
            for (int row = 0; row < `AER_ARRAY_PIXELS; row++) begin
                for (int col = 0; col < `AER_ARRAY_PIXELS; col++) begin
                    if (ack_i[row][col]) begin
                        pend_q[row][col] <= event_i[row][col];
                    end else begin
                        pend_q[row][col] <= pend_q[row][col] | event_i[row][col];
                    end
                end
            end
        end
    end

    assign pend_o = pend_q;

endmodule

`default_nettype wire

//--- hdl/pixel_level.sv
`default_nettype none

`include "aer_settings.svh"

module pixel_level #(
    parameter int GROUP_SIZE = 2,
    parameter int Lvl_ADD    = 1
) (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic enable_i,
    input  wire aer_pkg::polarity_t [GROUP_SIZE-1:0][GROUP_SIZE-1:0] req_i,
    input  wire logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0] mask_i,
    output logic req_o,
    output logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0] gnt_o,
    output logic [Lvl_ADD-1:0] x_add_o,
    output logic [Lvl_ADD-1:0] y_add_o,
    output logic active_o,
    output logic grp_release_o
);

    localparam int NUM_PIX = GROUP_SIZE * GROUP_SIZE;
    localparam int IDX_W   = 2 * Lvl_ADD;

    logic [NUM_PIX-1:0] raw_flat;
    logic [NUM_PIX-1:0] pend_flat;
    logic [NUM_PIX-1:0] others;
    logic [IDX_W-1:0]   last_q;
    logic [IDX_W-1:0]   sel_idx;
    logic               sel_found;
    logic               hold_off;
    logic               grant_on;

    // Index is row * GROUP_SIZE + col, so the low half is x and the high half y
    for (genvar row = 0; row < GROUP_SIZE; row++) begin : g_row
        for (genvar col = 0; col < GROUP_SIZE; col++) begin : g_col
            assign raw_flat[row*GROUP_SIZE+col]  = |req_i[row][col];
            assign pend_flat[row*GROUP_SIZE+col] = raw_flat[row*GROUP_SIZE+col]
                                                   & ~mask_i[row][col];
            assign gnt_o[row][col] = grant_on && (sel_idx == IDX_W'(row*GROUP_SIZE+col));
        end
    end

    // Search starts just after the pixel served last
    always_comb begin
        logic [IDX_W-1:0] idx;
        sel_idx   = '0;
        sel_found = 1'b0;
        for (int i = 1; i <= NUM_PIX; i++) begin
            idx = last_q + IDX_W'(i);
            if (!sel_found && pend_flat[idx]) begin
                sel_idx   = idx;
                sel_found = 1'b1;
            end
        end
    end

    // Nothing is granted while an acknowledge for this group is still in flight
    assign hold_off = |mask_i;
    assign grant_on = enable_i && sel_found && !hold_off;

    assign others        = pend_flat & ~(NUM_PIX'(1) << sel_idx);
    assign grp_release_o = grant_on && !(|others);

    assign x_add_o  = sel_idx[Lvl_ADD-1:0];
    assign y_add_o  = sel_idx[IDX_W-1:Lvl_ADD];
    assign req_o    = |pend_flat;
    assign active_o = |raw_flat;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            last_q <= '1;
        end else if (grant_on) begin
            last_q <= sel_idx;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pixel_groups_l0.sv
`default_nettype none

`include "aer_settings.svh"

module pixel_groups_l0 (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire aer_pkg::polarity_t [`AER_ARRAY_PIXELS-1:0][`AER_ARRAY_PIXELS-1:0] set_i,
    input  wire logic [`AER_ARRAY_PIXELS-1:0][`AER_ARRAY_PIXELS-1:0] mask_i,
    input  wire logic [`AER_GROUPS_PER_SIDE-1:0][`AER_GROUPS_PER_SIDE-1:0] gnt_top_i,
    output logic [`AER_GROUPS_PER_SIDE-1:0][`AER_GROUPS_PER_SIDE-1:0] req_o,
    output logic grp_release_o,
    output logic [`AER_GROUP_SIZE-1:0][`AER_GROUP_SIZE-1:0] gnt_o,
    output logic [`AER_LVL_ADD-1:0] x_add_o,
    output logic [`AER_LVL_ADD-1:0] y_add_o,
    output logic active_o
);

    aer_pkg::polarity_t [`AER_NUM_GROUPS-1:0][`AER_GROUP_SIZE-1:0][`AER_GROUP_SIZE-1:0] set_group;
    logic [`AER_NUM_GROUPS-1:0][`AER_GROUP_SIZE-1:0][`AER_GROUP_SIZE-1:0] mask_group;
    logic [`AER_NUM_GROUPS-1:0][`AER_GROUP_SIZE-1:0][`AER_GROUP_SIZE-1:0] gnt_temp;
    logic [`AER_NUM_GROUPS-1:0][`AER_LVL_ADD-1:0] x_add_temp;
    logic [`AER_NUM_GROUPS-1:0][`AER_LVL_ADD-1:0] y_add_temp;
    logic [`AER_NUM_GROUPS-1:0] active_temp;
    logic [`AER_NUM_GROUPS-1:0] release_temp;

    for (genvar grp = 0; grp < `AER_NUM_GROUPS; grp++) begin : g_group
        localparam int BASE_ROW = (grp / `AER_GROUPS_PER_SIDE) * `AER_GROUP_SIZE;
        localparam int BASE_COL = (grp % `AER_GROUPS_PER_SIDE) * `AER_GROUP_SIZE;

        // Slice this group's pixels out of the full array
        for (genvar row = 0; row < `AER_GROUP_SIZE; row++) begin : g_row
            for (genvar col = 0; col < `AER_GROUP_SIZE; col++) begin : g_col
                assign set_group[grp][row][col]  = set_i[BASE_ROW+row][BASE_COL+col];
                assign mask_group[grp][row][col] = mask_i[BASE_ROW+row][BASE_COL+col];
            end
        end

        pixel_level #(
            .GROUP_SIZE(`AER_GROUP_SIZE),
            .Lvl_ADD   (`AER_LVL_ADD)
        ) i_pixel_level (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .enable_i     (gnt_top_i[grp/`AER_GROUPS_PER_SIDE][grp%`AER_GROUPS_PER_SIDE]),
            .req_i        (set_group[grp]),
            .mask_i       (mask_group[grp]),
            .req_o        (req_o[grp/`AER_GROUPS_PER_SIDE][grp%`AER_GROUPS_PER_SIDE]),
            .gnt_o        (gnt_temp[grp]),
            .x_add_o      (x_add_temp[grp]),
            .y_add_o      (y_add_temp[grp]),
            .active_o     (active_temp[grp]),
            .grp_release_o(release_temp[grp])
        );
    end

    assign active_o = |active_temp;

    // The root grant is one-hot, so at most one group drives the outputs
    always_comb begin
        gnt_o         = '0;
        x_add_o       = '0;
        y_add_o       = '0;
        grp_release_o = 1'b0;
        for (int grp = 0; grp < `AER_NUM_GROUPS; grp++) begin
            if (gnt_top_i[grp/`AER_GROUPS_PER_SIDE][grp%`AER_GROUPS_PER_SIDE]) begin
                gnt_o         = gnt_temp[grp];
                x_add_o       = x_add_temp[grp];
                y_add_o       = y_add_temp[grp];
                grp_release_o = release_temp[grp];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/group_root_arbiter.sv
`default_nettype none

`include "aer_settings.svh"

module group_root_arbiter (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic [`AER_GROUPS_PER_SIDE-1:0][`AER_GROUPS_PER_SIDE-1:0] req_i,
    input  wire logic grp_release_i,
    output logic [`AER_GROUPS_PER_SIDE-1:0][`AER_GROUPS_PER_SIDE-1:0] gnt_o,
    output aer_pkg::group_idx_t grp_idx_o,
    output logic gnt_valid_o
);

    aer_pkg::root_state_t       state_q;
    aer_pkg::group_idx_t        last_q;
    aer_pkg::group_idx_t        next_idx;
    logic                       next_found;
    logic [`AER_NUM_GROUPS-1:0] req_flat;
    logic [`AER_NUM_GROUPS-1:0] gnt_q;

    for (genvar grp = 0; grp < `AER_NUM_GROUPS; grp++) begin : g_flat
        assign req_flat[grp] = req_i[grp/`AER_GROUPS_PER_SIDE][grp%`AER_GROUPS_PER_SIDE];
        assign gnt_o[grp/`AER_GROUPS_PER_SIDE][grp%`AER_GROUPS_PER_SIDE] = gnt_q[grp];
    end

    // Round-robin pick starts after the group served last
    always_comb begin
        aer_pkg::group_idx_t idx;
        next_idx   = last_q;
        next_found = 1'b0;
        for (int i = 1; i <= `AER_NUM_GROUPS; i++) begin
            idx = last_q + aer_pkg::group_idx_t'(i);
            if (!next_found && req_flat[idx]) begin
                next_idx   = idx;
                next_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= aer_pkg::ROOT_IDLE;
            gnt_q     <= '0;
            grp_idx_o <= '0;
            last_q    <= aer_pkg::group_idx_t'(`AER_NUM_GROUPS - 1);
        end else begin
            unique case (state_q)
                aer_pkg::ROOT_IDLE: begin
                    if (next_found) begin
                        gnt_q           <= '0;
                        gnt_q[next_idx] <= 1'b1;
                        grp_idx_o       <= next_idx;
                        last_q          <= next_idx;
                        state_q         <= aer_pkg::ROOT_SERVE;
                    end
                end
                aer_pkg::ROOT_SERVE: begin
                    if (grp_release_i) begin
                        gnt_q   <= '0;
                        state_q <= aer_pkg::ROOT_IDLE;
                    end
                end
                default: begin
                    gnt_q   <= '0;
                    state_q <= aer_pkg::ROOT_IDLE;
                end
            endcase
        end
    end

    assign gnt_valid_o = (state_q == aer_pkg::ROOT_SERVE);

endmodule

`default_nettype wire

//--- hdl/aer_address_encoder.sv
`default_nettype none

`include "aer_settings.svh"

module aer_address_encoder (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic gnt_valid_i,
    input  wire aer_pkg::group_idx_t grp_idx_i,
    input  wire logic [`AER_GROUP_SIZE-1:0][`AER_GROUP_SIZE-1:0] local_gnt_i,
    input  wire logic [`AER_LVL_ADD-1:0] x_add_i,
    input  wire logic [`AER_LVL_ADD-1:0] y_add_i,
    input  wire aer_pkg::polarity_t [`AER_ARRAY_PIXELS-1:0][`AER_ARRAY_PIXELS-1:0] pend_i,
    output logic aer_valid_o,
    output aer_pkg::addr_t aer_x_o,
    output aer_pkg::addr_t aer_y_o,
    output aer_pkg::polarity_t aer_pol_o,
    output logic [`AER_ARRAY_PIXELS-1:0][`AER_ARRAY_PIXELS-1:0] ack_o,
    output logic [`AER_ARRAY_PIXELS-1:0][`AER_ARRAY_PIXELS-1:0] mask_o
);

    aer_pkg::addr_t     grp_row;
    aer_pkg::addr_t     grp_col;
    aer_pkg::addr_t     x_glb;
    aer_pkg::addr_t     y_glb;
    aer_pkg::polarity_t pol;
    logic               fire;
    logic [`AER_ARRAY_PIXELS-1:0][`AER_ARRAY_PIXELS-1:0] ack_q;

    assign grp_row = aer_pkg::addr_t'(grp_idx_i / `AER_GROUPS_PER_SIDE);
    assign grp_col = aer_pkg::addr_t'(grp_idx_i % `AER_GROUPS_PER_SIDE);
    assign x_glb   = aer_pkg::addr_t'(grp_col * `AER_GROUP_SIZE) + aer_pkg::addr_t'(x_add_i);
    assign y_glb   = aer_pkg::addr_t'(grp_row * `AER_GROUP_SIZE) + aer_pkg::addr_t'(y_add_i);
    assign pol     = pend_i[y_glb][x_glb];

    // A pixel whose acknowledge is still travelling to the latch is not read again
    assign fire = gnt_valid_i && (|local_gnt_i) && !ack_q[y_glb][x_glb];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            aer_valid_o <= 1'b0;
            ack_q       <= '0;
        end else begin
            aer_valid_o <= fire;
            ack_q       <= '0;
            if (fire) begin
                ack_q[y_glb][x_glb] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) begin
            aer_x_o   <= x_glb;
            aer_y_o   <= y_glb;
            aer_pol_o <= pol;
        end
    end

    assign ack_o  = ack_q;
    assign mask_o = ack_q;

endmodule

`default_nettype wire

//--- hdl/aer_readout_top.sv
`default_nettype none

`include "aer_settings.svh"

module aer_readout_top (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire aer_pkg::polarity_t [`AER_ARRAY_PIXELS-1:0][`AER_ARRAY_PIXELS-1:0] event_i,
    output logic aer_valid_o,
    output aer_pkg::addr_t aer_x_o,
    output aer_pkg::addr_t aer_y_o,
    output aer_pkg::polarity_t aer_pol_o,
    output logic active_o
);

    aer_pkg::polarity_t [`AER_ARRAY_PIXELS-1:0][`AER_ARRAY_PIXELS-1:0] pend;
    logic [`AER_ARRAY_PIXELS-1:0][`AER_ARRAY_PIXELS-1:0] ack_map;
    logic [`AER_ARRAY_PIXELS-1:0][`AER_ARRAY_PIXELS-1:0] mask_map;
    logic [`AER_GROUPS_PER_SIDE-1:0][`AER_GROUPS_PER_SIDE-1:0] grp_req;
    logic [`AER_GROUPS_PER_SIDE-1:0][`AER_GROUPS_PER_SIDE-1:0] grp_gnt;
    logic [`AER_GROUP_SIZE-1:0][`AER_GROUP_SIZE-1:0] local_gnt;
    logic [`AER_LVL_ADD-1:0] x_add;
    logic [`AER_LVL_ADD-1:0] y_add;
    logic                    grp_release;
    logic                    gnt_valid;
    aer_pkg::group_idx_t     grp_idx;

    pixel_event_latch i_latch (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .event_i(event_i),
        .ack_i  (ack_map),
        .pend_o (pend)
    );

    pixel_groups_l0 i_groups (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .set_i        (pend),
        .mask_i       (mask_map),
        .gnt_top_i    (grp_gnt),
        .req_o        (grp_req),
        .grp_release_o(grp_release),
        .gnt_o        (local_gnt),
        .x_add_o      (x_add),
        .y_add_o      (y_add),
        .active_o     (active_o)
    );

    group_root_arbiter i_root (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (grp_req),
        .grp_release_i(grp_release),
        .gnt_o        (grp_gnt),
        .grp_idx_o    (grp_idx),
        .gnt_valid_o  (gnt_valid)
    );

    aer_address_encoder i_encoder (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .gnt_valid_i(gnt_valid),
        .grp_idx_i  (grp_idx),
        .local_gnt_i(local_gnt),
        .x_add_i    (x_add),
        .y_add_i    (y_add),
        .pend_i     (pend),
        .aer_valid_o(aer_valid_o),
        .aer_x_o    (aer_x_o),
        .aer_y_o    (aer_y_o),
        .aer_pol_o  (aer_pol_o),
        .ack_o      (ack_map),
        .mask_o     (mask_map)
    );

endmodule

`default_nettype wire

//--- verif/aer_readout_props.sv
`default_nettype none

`include "aer_settings.svh"

module aer_readout_props (
    input wire logic clk_i,
    input wire logic rst_i,
    input wire logic [`AER_GROUPS_PER_SIDE-1:0][`AER_GROUPS_PER_SIDE-1:0] grp_gnt_i,
    input wire logic [`AER_ARRAY_PIXELS-1:0][`AER_ARRAY_PIXELS-1:0] ack_i,
    input wire logic aer_valid_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read by the testbench at the end of the run
    int assert_fails = 0;

    root_gnt_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(grp_gnt_i))
        else begin
            assert_fails++;
            $error("root grant is not one-hot or zero");
        end

    // Each word acknowledges exactly one pixel
    ack_onehot: assert property (@(posedge clk_i) disable iff (rst_i) aer_valid_i |-> $onehot(ack_i))
        else begin
            assert_fails++;
            $error("ack map is not one-hot while a word is valid");
        end

    valid_low_in_reset: assert property (@(posedge clk_i) rst_i |=> !aer_valid_i)
        else begin
            assert_fails++;
            $error("aer_valid_o is high after a reset cycle");
        end

endmodule

bind aer_readout_top aer_readout_props i_props (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .grp_gnt_i  (grp_gnt),
    .ack_i      (ack_map),
    .aer_valid_i(aer_valid_o)
);

`default_nettype wire

//--- verif/aer_readout_tb.sv
`default_nettype none

`include "aer_settings.svh"

module aer_readout_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N           = `AER_ARRAY_PIXELS;
    localparam int GS          = `AER_GROUP_SIZE;
    localparam int GPS         = `AER_GROUPS_PER_SIDE;
    localparam int DRAIN_LIMIT = 256;

    typedef aer_pkg::polarity_t [N-1:0][N-1:0] event_map_t;

    logic               clk;
    logic               rst;
    event_map_t         event_map;
    logic               aer_valid;
    aer_pkg::addr_t     aer_x;
    aer_pkg::addr_t     aer_y;
    aer_pkg::polarity_t aer_pol;
    logic               active;

    // Scoreboard of polarity bits that each pixel still owes the readout
    event_map_t  expected;
    int          seen [N][N];
    int          group_words [`AER_NUM_GROUPS];
    int          word_count;
    int          cur_grp;
    bit          track_groups;
    logic [15:0] lfsr_state;

    aer_readout_top aer_readout_top_i (
        .clk_i      (clk),
        .rst_i      (rst),
        .event_i    (event_map),
        .aer_valid_o(aer_valid),
        .aer_x_o    (aer_x),
        .aer_y_o    (aer_y),
        .aer_pol_o  (aer_pol),
        .active_o   (active)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 16, 14, 13, 11
    function automatic logic take_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input int actual, input int exp_val, input string what);
        if (actual != exp_val) begin
            $display("CHECK FAILED at time %0t: %s (got %0d, expected %0d)",
                     $time, what, actual, exp_val);
            abort_run();
        end
    endtask

    task automatic clear_tracking();
        word_count   = 0;
        cur_grp      = -1;
        track_groups = 1'b0;
        foreach (seen[y, x]) seen[y][x] = 0;
        foreach (group_words[g]) group_words[g] = 0;
    endtask

    // Starts and ends on a falling edge; the word seen here was registered at the rising edge
    task automatic run_cycle(input event_map_t strobes);
        event_map_t next_exp;
        int         x;
        int         y;
        int         grp;
        event_map = strobes;
        @(posedge clk);
        @(negedge clk);
        event_map = '0;
        next_exp  = expected | strobes;
        if (aer_valid) begin
            x = int'(aer_x);
            y = int'(aer_y);
            check_value(int'(aer_pol), int'(expected[y][x]),
                        $sformatf("polarity of the word for x=%0d y=%0d", x, y));
            // A strobe taken at the word's edge is wiped by the ack one edge later
            next_exp[y][x] = '0;
            seen[y][x]++;
            word_count++;
            grp = (y / GS) * GPS + (x / GS);
            if (track_groups && grp != cur_grp) begin
                if (cur_grp >= 0) begin
                    check_value(group_words[cur_grp], GS * GS, "words of a group left early");
                end
                check_value(group_words[grp], 0, "words of a group served twice");
                cur_grp = grp;
            end
            group_words[grp]++;
        end
        expected = next_exp;
    endtask

    task automatic drain_readout();
        int waited;
        waited = 0;
        while ((active || aer_valid) && waited < DRAIN_LIMIT) begin
            run_cycle('0);
            waited++;
        end
        if (active || aer_valid) begin
            $display("ERROR: readout did not drain within %0d cycles", DRAIN_LIMIT);
            abort_run();
        end
        foreach (seen[y, x]) begin
            check_value(int'(expected[y][x]), 0,
                        $sformatf("missing word for x=%0d y=%0d", x, y));
        end
    endtask

    task automatic idle_after_reset();
        for (int c = 0; c < 20; c++) begin
            run_cycle('0);
            check_value(aer_valid, 0, "aer_valid_o while idle");
            check_value(active, 0, "active_o while idle");
        end
    endtask

    task automatic single_pixel(input int x, input int y, input aer_pkg::polarity_t pol);
        event_map_t strobes;
        int         waited;
        clear_tracking();
        strobes       = '0;
        strobes[y][x] = pol;
        run_cycle(strobes);
        waited = 0;
        while (!aer_valid && waited < DRAIN_LIMIT) begin
            run_cycle('0);
            waited++;
        end
        if (!aer_valid) begin
            $display("ERROR: no word for x=%0d y=%0d within %0d cycles", x, y, DRAIN_LIMIT);
            abort_run();
        end
        check_value(active, 1, "active_o while the word is out");
        // The ack clears the latch one edge after the word
        run_cycle('0);
        check_value(active, 0, "active_o one cycle after the word");
        drain_readout();
        check_value(word_count, 1, "number of words for one event");
        check_value(seen[y][x], 1, "words at the strobed pixel");
    endtask

    task automatic full_group();
        event_map_t strobes;
        clear_tracking();
        strobes = '0;
        for (int y = 2; y < 4; y++) begin
            for (int x = 2; x < 4; x++) begin
                strobes[y][x] = 2'b10;
            end
        end
        run_cycle(strobes);
        drain_readout();
        check_value(word_count, 4, "number of words for one full group");
        for (int y = 2; y < 4; y++) begin
            for (int x = 2; x < 4; x++) begin
                check_value(seen[y][x], 1, $sformatf("words at x=%0d y=%0d", x, y));
            end
        end
    endtask

    task automatic whole_array();
        event_map_t strobes;
        clear_tracking();
        track_groups = 1'b1;
        foreach (seen[y, x]) strobes[y][x] = aer_pkg::polarity_t'(((x + y) % 3) + 1);
        run_cycle(strobes);
        drain_readout();
        check_value(group_words[cur_grp], GS * GS, "words of the last group");
        check_value(word_count, N * N, "number of words for the whole array");
        foreach (seen[y, x]) check_value(seen[y][x], 1, $sformatf("words at x=%0d y=%0d", x, y));
    endtask

    task automatic random_traffic();
        event_map_t         strobes;
        logic [3:0]         gate;
        aer_pkg::polarity_t pol;
        clear_tracking();
        for (int c = 0; c < 200; c++) begin
            strobes = '0;
            foreach (seen[y, x]) begin
                gate = {take_bit(), take_bit(), take_bit(), take_bit()};
                pol  = {take_bit(), take_bit()};
                if (gate == 4'hf) strobes[y][x] = pol;
            end
            run_cycle(strobes);
        end
        drain_readout();
        check_value(int'(word_count > 0), 1, "any word during random traffic");
    endtask

    initial begin
        rst        = 1'b1;
        event_map  = '0;
        expected   = '0;
        lfsr_state = 16'd61;
        clear_tracking();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        idle_after_reset();
        single_pixel(2, 1, 2'b01);
        single_pixel(0, 3, 2'b11);
        full_group();
        whole_array();
        random_traffic();
        if (aer_readout_top_i.i_props.assert_fails != 0) begin
            $display("ERROR: %0d bound assertions failed",
                     aer_readout_top_i.i_props.assert_fails);
            abort_run();
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/aer_pkg.sv
hdl/pixel_event_latch.sv
hdl/pixel_level.sv
hdl/pixel_groups_l0.sv
hdl/group_root_arbiter.sv
hdl/aer_address_encoder.sv
hdl/aer_readout_top.sv
verif/aer_readout_props.sv
verif/aer_readout_tb.sv

//--- Bender.yml
package:
  name: aer_readout

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/aer_pkg.sv
      - hdl/pixel_event_latch.sv
      - hdl/pixel_level.sv
      - hdl/pixel_groups_l0.sv
      - hdl/group_root_arbiter.sv
      - hdl/aer_address_encoder.sv
      - hdl/aer_readout_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/aer_readout_props.sv
      - verif/aer_readout_tb.sv
